// ==== logic/smc_bus_pkg.sv ====
//----------------------------------------------------------------------------
// AHB-lite and external bus constants, widths and transfer codes
//----------------------------------------------------------------------------
`default_nettype none

package smc_bus_pkg;

  localparam int DATA_W = 32;            // AHB and external data width
  localparam int ADDR_W = 32;
  localparam int LANES  = DATA_W / 8;    // Byte lanes on the external bus

  // htrans codes
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // hsize codes, only up to bus width
  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  localparam logic [1:0] HRESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== logic/smc_timing_pkg.sv ====
//----------------------------------------------------------------------------
// Access phase lengths, sequencer state type and derived counts
//----------------------------------------------------------------------------
`default_nettype none

package smc_timing_pkg;

  localparam int CSLE_CYCLES = 1;   // CS lead, keep >= 1 so write data lands first
  localparam int WS_CYCLES   = 2;   // Wait states, strobe is WS_CYCLES + 1 long
  localparam int CSTE_CYCLES = 1;   // Bus float after CS

  localparam int STROBE_CYCLES = WS_CYCLES + 1;
  localparam int ACCESS_CYCLES = CSLE_CYCLES + STROBE_CYCLES + CSTE_CYCLES;

  // Phase counter sized by the longest phase
  localparam int MAX_PHASE = (CSLE_CYCLES > STROBE_CYCLES) ?
                             ((CSLE_CYCLES > CSTE_CYCLES) ? CSLE_CYCLES : CSTE_CYCLES) :
                             ((STROBE_CYCLES > CSTE_CYCLES) ? STROBE_CYCLES : CSTE_CYCLES);
  localparam int CNT_W = $clog2(MAX_PHASE + 1);

  // Counter reload values, counts down to zero in each phase
  localparam int CSLE_LOAD   = CSLE_CYCLES - 1;
  localparam int STROBE_LOAD = WS_CYCLES;
  localparam int CSTE_LOAD   = (CSTE_CYCLES > 0) ? CSTE_CYCLES - 1 : 0;

  typedef enum logic [1:0] {IDLE, LEAD, STROBE, TRAIL} smc_state_t;

endpackage

`default_nettype wire

// ==== logic/smc_ahb_slave.sv ====
//----------------------------------------------------------------------------
// AHB-lite slave: address and data phase capture, hready, read data return
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module smc_ahb_slave import smc_bus_pkg::*; (
  input  logic              hclk,
  input  logic              rst,
  input  logic              hsel,
  input  logic [1:0]        htrans,
  input  logic              hwrite,
  input  logic [2:0]        hsize,
  input  logic [ADDR_W-1:0] haddr,
  input  logic [DATA_W-1:0] hwdata,
  input  logic              hready,       // Muxed ready from the bus
  input  logic [DATA_W-1:0] data_smc,     // External read data
  input  logic              strobe_last,
  input  logic              smc_done,
  output logic              new_access,   // Accepted address phase
  output logic [ADDR_W-1:0] acc_addr,
  output logic              acc_write,
  output logic [2:0]        acc_size,
  output logic [DATA_W-1:0] write_data,
  output logic              smc_hready,
  output logic [DATA_W-1:0] smc_hrdata
);

  logic xfer_valid;    // NONSEQ or SEQ to this slave
  logic wdata_phase;   // First data cycle of a write

  assign xfer_valid = hsel && ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));
  // Own ready in the term too, so a held address phase is not taken twice
  assign new_access = xfer_valid && hready && smc_hready;

  // Data phase control
  always_ff @(posedge hclk) begin
    if (rst) begin
      smc_hready  <= 1'b1;
      wdata_phase <= 1'b0;
      acc_write   <= 1'b0;
    end else begin
      wdata_phase <= new_access && hwrite;
      if (new_access) begin
        smc_hready <= 1'b0;           // Stretch until access ends
        acc_write  <= hwrite;
      end else if (smc_done) begin
        smc_hready <= 1'b1;
      end
    end
  end

  // Address phase fields
  always_ff @(posedge hclk) begin
    if (new_access) begin
      acc_addr <= haddr;
      acc_size <= hsize;
    end
  end

  // hwdata is valid one cycle after the address phase
  always_ff @(posedge hclk) begin
    if (wdata_phase) begin
      write_data <= hwdata;
    end
    if (strobe_last && !acc_write) begin
      smc_hrdata <= data_smc;         // Sample at end of read strobe
    end
  end

endmodule

`default_nettype wire

// ==== logic/smc_sequencer.sv ====
//----------------------------------------------------------------------------
// Access FSM with its phase down-counter, last strobe and done flags
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module smc_sequencer import smc_timing_pkg::*; (
  input  logic       hclk,
  input  logic       rst,
  input  logic       new_access,
  output smc_state_t state,
  output logic       strobe_last,   // Last STROBE cycle
  output logic       smc_done       // Last cycle of the access
);

  smc_state_t       state_d;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic             cnt_zero;

  assign cnt_zero    = (cnt_q == '0);
  assign strobe_last = (state == STROBE) && cnt_zero;
  // No trail phase means the strobe ends the access
  assign smc_done    = ((state == TRAIL) && cnt_zero) ||
                       ((CSTE_CYCLES == 0) && strobe_last);

  //--------------------------------------------------------------------------
  // Next state and counter reload
  //--------------------------------------------------------------------------
  always_comb begin
    state_d = state;
    cnt_d   = cnt_q;
    if (!cnt_zero) begin
      cnt_d = cnt_q - 1'b1;          // Count down inside a phase
    end

    case (state)
      IDLE: begin
        if (new_access) begin
          state_d = LEAD;
          cnt_d   = CNT_W'(CSLE_LOAD);
        end
      end

      LEAD: begin
        if (cnt_zero) begin
          state_d = STROBE;
          cnt_d   = CNT_W'(STROBE_LOAD);
        end
      end

      STROBE: begin
        if (cnt_zero) begin
          if (CSTE_CYCLES > 0) begin
            state_d = TRAIL;
            cnt_d   = CNT_W'(CSTE_LOAD);
          end else if (new_access) begin
            state_d = LEAD;           // Straight into next access
            cnt_d   = CNT_W'(CSLE_LOAD);
          end else begin
            state_d = IDLE;
          end
        end
      end

      TRAIL: begin
        if (cnt_zero) begin
          if (new_access) begin
            state_d = LEAD;
            cnt_d   = CNT_W'(CSLE_LOAD);
          end else begin
            state_d = IDLE;
          end
        end
      end

      default: begin
        state_d = IDLE;
        cnt_d   = '0;
      end
    endcase
  end

  //--------------------------------------------------------------------------
  // State and counter registers
  //--------------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      state <= IDLE;
      cnt_q <= '0;
    end else begin
      state <= state_d;
      cnt_q <= cnt_d;
    end
  end

endmodule

`default_nettype wire

// ==== logic/smc_strobe.sv ====
//----------------------------------------------------------------------------
// Registered read, write and output-enable strobes plus busy flag
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module smc_strobe import smc_bus_pkg::*, smc_timing_pkg::*; (
  input  logic             hclk,
  input  logic             rst,
  input  smc_state_t       state,
  input  logic             acc_write,
  input  logic [LANES-1:0] n_be,          // Active-low lane enables
  output logic             smc_n_rd,
  output logic [LANES-1:0] smc_n_we,
  output logic             smc_n_wr,
  output logic             smc_n_ext_oe,
  output logic             smc_busy
);

  logic             cs_window;     // LEAD or STROBE
  logic             rd_n_d;
  logic [LANES-1:0] we_n_d;
  logic             wr_n_d;

  assign cs_window = (state == LEAD) || (state == STROBE);

  // Decoded strobe levels, one cycle ahead of the pins
  always_comb begin
    rd_n_d = !((state == STROBE) && !acc_write);
    we_n_d = ((state == STROBE) && acc_write) ? n_be : '1;
    wr_n_d = !(cs_window && acc_write);  // Covers CS lead for data setup
  end

  // Glitch-free pins
  always_ff @(posedge hclk) begin
    if (rst) begin
      smc_n_rd     <= 1'b1;
      smc_n_we     <= '1;
      smc_n_wr     <= 1'b1;
      smc_n_ext_oe <= 1'b1;
      smc_busy     <= 1'b0;
    end else begin
      smc_n_rd     <= rd_n_d;
      smc_n_we     <= we_n_d;
      smc_n_wr     <= wr_n_d;
      smc_n_ext_oe <= wr_n_d;        // Own flop next to the data pads
      smc_busy     <= (state != IDLE);
    end
  end

endmodule

`default_nettype wire

// ==== logic/smc_addr.sv ====
//----------------------------------------------------------------------------
// External address, byte enables and chip select
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module smc_addr import smc_bus_pkg::*, smc_timing_pkg::*; (
  input  logic              hclk,
  input  logic              rst,
  input  smc_state_t        state,
  input  logic [ADDR_W-1:0] acc_addr,
  input  logic [2:0]        acc_size,
  output logic [ADDR_W-1:0] smc_addr,
  output logic [LANES-1:0]  n_be,       // Unregistered, also to strobes
  output logic [LANES-1:0]  smc_n_be,
  output logic              smc_n_cs
);

  logic cs_window;

  assign cs_window = (state == LEAD) || (state == STROBE);

  // Lane select from size and low address bits, aligned transfers only
  always_comb begin
    case (acc_size)
      HSIZE_BYTE: n_be = ~(LANES'(1) << acc_addr[1:0]);
      HSIZE_HALF: n_be = acc_addr[1] ? 4'b0011 : 4'b1100;
      HSIZE_WORD: n_be = '0;
      default:    n_be = '1;        // Wider than the bus, no lanes
    endcase
  end

  always_ff @(posedge hclk) begin
    smc_addr <= acc_addr;
  end

  always_ff @(posedge hclk) begin
    if (rst) begin
      smc_n_be <= '1;
      smc_n_cs <= 1'b1;
    end else begin
      smc_n_be <= cs_window ? n_be : '1;
      smc_n_cs <= !cs_window;
    end
  end

endmodule

`default_nettype wire

// ==== logic/smc_lite.sv ====
//----------------------------------------------------------------------------
// Static memory controller top, AHB-lite to async SRAM bus
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module smc_lite import smc_bus_pkg::*, smc_timing_pkg::*; (
  input  logic              hclk,
  input  logic              rst,
  // AHB-lite slave
  input  logic              hsel,
  input  logic [1:0]        htrans,
  input  logic              hwrite,
  input  logic [2:0]        hsize,
  input  logic [ADDR_W-1:0] haddr,
  input  logic [DATA_W-1:0] hwdata,
  input  logic              hready,
  output logic              smc_hready,
  output logic [DATA_W-1:0] smc_hrdata,
  output logic [1:0]        smc_hresp,
  // External memory bus
  output logic [ADDR_W-1:0] smc_addr,
  output logic [DATA_W-1:0] smc_data,
  input  logic [DATA_W-1:0] data_smc,
  output logic [LANES-1:0]  smc_n_be,
  output logic              smc_n_cs,
  output logic              smc_n_rd,
  output logic [LANES-1:0]  smc_n_we,
  output logic              smc_n_wr,
  output logic              smc_n_ext_oe,
  output logic              smc_busy
);

  logic              new_access;
  logic [ADDR_W-1:0] acc_addr;
  logic              acc_write;
  logic [2:0]        acc_size;
  logic [DATA_W-1:0] write_data;
  smc_state_t        state;
  logic              strobe_last;
  logic              smc_done;
  logic [LANES-1:0]  n_be;

  assign smc_hresp = HRESP_OKAY;      // Aligned transfers, never errors
  assign smc_data  = write_data;

  smc_ahb_slave u_ahb_slave (
    .hclk, .rst, .hsel, .htrans, .hwrite, .hsize, .haddr, .hwdata, .hready,
    .data_smc, .strobe_last, .smc_done, .new_access, .acc_addr, .acc_write,
    .acc_size, .write_data, .smc_hready, .smc_hrdata
  );

  smc_sequencer u_sequencer (
    .hclk, .rst, .new_access, .state, .strobe_last, .smc_done
  );

  smc_strobe u_strobe (
    .hclk, .rst, .state, .acc_write, .n_be,
    .smc_n_rd, .smc_n_we, .smc_n_wr, .smc_n_ext_oe, .smc_busy
  );

  smc_addr u_addr (
    .hclk, .rst, .state, .acc_addr, .acc_size,
    .smc_addr, .n_be, .smc_n_be, .smc_n_cs
  );

endmodule

`default_nettype wire

// ==== dv/smc_lite_sva.sv ====
//----------------------------------------------------------------------------
// Protocol assertions on the external strobes, bound into smc_lite
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module smc_lite_sva import smc_bus_pkg::*; (
  input logic             hclk,
  input logic             rst,
  input logic             smc_n_rd,
  input logic [LANES-1:0] smc_n_we,
  input logic             smc_n_wr,
  input logic             smc_n_cs,
  input logic             smc_busy
);

  // Read and write strobes are exclusive
  a_rd_we_excl: assert property (@(posedge hclk) disable iff (rst)
    !(!smc_n_rd && (smc_n_we != '1)))
    else $error("read and write strobes active together");

  // Any strobe only inside chip select
  a_strobe_in_cs: assert property (@(posedge hclk) disable iff (rst)
    (!smc_n_rd || !smc_n_wr || (smc_n_we != '1)) |-> !smc_n_cs)
    else $error("strobe active with chip select high");

  a_cs_busy: assert property (@(posedge hclk) disable iff (rst)
    !smc_n_cs |-> smc_busy)
    else $error("chip select low while not busy");

endmodule

bind smc_lite smc_lite_sva u_sva (
  .hclk, .rst, .smc_n_rd, .smc_n_we, .smc_n_wr, .smc_n_cs, .smc_busy
);

`default_nettype wire

// ==== dv/smc_lite_tb.sv ====
//----------------------------------------------------------------------------
// Testbench for smc_lite with SRAM model, stimulus table and checks
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module smc_lite_tb import smc_bus_pkg::*, smc_timing_pkg::*; ();

  localparam int N_ENTRIES = 16;
  // Table length plus margin for reset and idle-transfer checks
  localparam int WATCHDOG_CYCLES = (N_ENTRIES + 4) * (ACCESS_CYCLES + 4);

  logic              hclk;
  logic              rst;
  logic              hsel;
  logic [1:0]        htrans;
  logic              hwrite;
  logic [2:0]        hsize;
  logic [ADDR_W-1:0] haddr;
  logic [DATA_W-1:0] hwdata;
  logic              hready;
  logic              smc_hready;
  logic [DATA_W-1:0] smc_hrdata;
  logic [1:0]        smc_hresp;
  logic [ADDR_W-1:0] smc_addr;
  logic [DATA_W-1:0] smc_data;
  logic [DATA_W-1:0] data_smc;
  logic [LANES-1:0]  smc_n_be;
  logic              smc_n_cs;
  logic              smc_n_rd;
  logic [LANES-1:0]  smc_n_we;
  logic              smc_n_wr;
  logic              smc_n_ext_oe;
  logic              smc_busy;

  logic [31:0] sram [16];       // External memory model
  logic [31:0] shadow [16];     // Expected contents
  logic [3:0]  we_prev;
  int          seed = 32'h0dbe_d449;
  int          error_count = 0;

  // Stimulus table
  logic        tbl_write [N_ENTRIES];
  logic [2:0]  tbl_size  [N_ENTRIES];
  logic [31:0] tbl_addr  [N_ENTRIES];
  logic [31:0] tbl_data  [N_ENTRIES];
  int          tbl_idle  [N_ENTRIES];

  smc_lite u_dut (.*);

  initial hclk = 1'b0;
  always #50 hclk = ~hclk;

  //--------------------------------------------------------------------------
  // SRAM model
  //--------------------------------------------------------------------------
  assign data_smc = !smc_n_rd ? sram[smc_addr[5:2]] : 32'h0;

  // Lane write on the rising edge of its strobe
  always @(smc_n_we) begin
    for (int l = 0; l < 4; l++) begin
      if (!rst && !we_prev[l] && smc_n_we[l])
        sram[smc_addr[5:2]][8*l +: 8] = smc_data[8*l +: 8];
    end
    we_prev = smc_n_we;
  end

  function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [31:0] addr);
    case (size)
      HSIZE_BYTE: lane_mask = 4'b0001 << addr[1:0];
      HSIZE_HALF: lane_mask = addr[1] ? 4'b1100 : 4'b0011;
      default:    lane_mask = 4'b1111;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
      $display("Verification failed");
      $fatal(1, "first error");
    end
  endtask

  task automatic set_entry(input int i, input logic w, input logic [2:0] s,
                           input logic [31:0] a, input int idle);
    tbl_write[i] = w;
    tbl_size[i]  = s;
    tbl_addr[i]  = a;
    tbl_data[i]  = w ? $random(seed) : 32'h0;
    tbl_idle[i]  = idle;
  endtask

  task automatic drive_addr(input int i);
    hsel   <= 1'b1;
    htrans <= HTRANS_NONSEQ;
    hwrite <= tbl_write[i];
    hsize  <= tbl_size[i];
    haddr  <= tbl_addr[i];
  endtask

  // Unselected or IDLE/BUSY cycles must not start an access
  task automatic check_ignored();
    for (int k = 0; k < 6; k++) begin
      @(posedge hclk);
      hsel   <= (k == 1) || (k == 2);
      htrans <= (k == 0) ? HTRANS_NONSEQ : (k == 2) ? HTRANS_BUSY : HTRANS_IDLE;
      @(negedge hclk);
      check_value("smc_n_cs", 32'(smc_n_cs), 32'h1);
      check_value("smc_hready", 32'(smc_hready), 32'h1);
    end
  endtask

  //--------------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------------
  initial begin
    logic       pending;
    int         low_cycles;
    logic [3:0] mask;
    logic [3:0] exp_n_be;
    for (int w = 0; w < 16; w++) begin
      sram[w]   = 32'h5a00_0000 ^ (32'(w) * 32'h0103_0507);
      shadow[w] = sram[w];
    end
    we_prev = 4'hf;
    rst = 1'b1;
    hsel = 1'b0;
    htrans = HTRANS_IDLE;
    hwrite = 1'b0;
    hsize = HSIZE_WORD;
    haddr = '0;
    hwdata = '0;
    hready = 1'b1;
    set_entry(0,  1'b1, HSIZE_WORD, 32'h00, 1);   // Word writes then reads
    set_entry(1,  1'b1, HSIZE_WORD, 32'h04, 0);
    set_entry(2,  1'b1, HSIZE_WORD, 32'h08, 0);
    set_entry(3,  1'b0, HSIZE_WORD, 32'h00, 1);
    set_entry(4,  1'b0, HSIZE_WORD, 32'h04, 0);
    set_entry(5,  1'b0, HSIZE_WORD, 32'h08, 0);
    set_entry(6,  1'b1, HSIZE_BYTE, 32'h0d, 1);   // Partial lanes
    set_entry(7,  1'b1, HSIZE_BYTE, 32'h0e, 0);
    set_entry(8,  1'b1, HSIZE_HALF, 32'h12, 0);
    set_entry(9,  1'b1, HSIZE_HALF, 32'h14, 0);
    set_entry(10, 1'b0, HSIZE_WORD, 32'h0c, 1);
    set_entry(11, 1'b0, HSIZE_WORD, 32'h10, 0);
    set_entry(12, 1'b0, HSIZE_WORD, 32'h14, 0);
    set_entry(13, 1'b1, HSIZE_WORD, 32'h3c, 0);
    set_entry(14, 1'b0, HSIZE_WORD, 32'h3c, 0);   // Read right after write
    set_entry(15, 1'b0, HSIZE_WORD, 32'h20, 2);   // Untouched word
    repeat (2) @(posedge hclk);
    rst <= 1'b0;

    // Reset values
    @(negedge hclk);
    check_value("smc_hready", 32'(smc_hready), 32'h1);
    check_value("smc_hresp", 32'(smc_hresp), 32'(HRESP_OKAY));
    check_value("smc_n_cs", 32'(smc_n_cs), 32'h1);
    check_value("smc_n_rd", 32'(smc_n_rd), 32'h1);
    check_value("smc_n_wr", 32'(smc_n_wr), 32'h1);
    check_value("smc_n_ext_oe", 32'(smc_n_ext_oe), 32'h1);
    check_value("smc_n_we", 32'(smc_n_we), 32'hf);
    check_value("smc_busy", 32'(smc_busy), 32'h0);

    check_ignored();

    pending = 1'b0;
    for (int i = 0; i < N_ENTRIES; i++) begin
      mask     = lane_mask(tbl_size[i], tbl_addr[i]);
      exp_n_be = ~mask;                      // Active-low lanes on the pins
      if (!pending) begin
        repeat (tbl_idle[i]) @(posedge hclk);
        @(posedge hclk);
        drive_addr(i);
        @(negedge hclk);
      end
      while (!smc_hready) @(negedge hclk);
      @(posedge hclk);                       // Acceptance edge
      hwdata <= tbl_data[i];
      if ((i + 1 < N_ENTRIES) && (tbl_idle[i + 1] == 0)) begin
        drive_addr(i + 1);                   // Next address phase overlaps
        pending = 1'b1;
      end else begin
        hsel   <= 1'b0;
        htrans <= HTRANS_IDLE;
        pending = 1'b0;
      end
      low_cycles = 0;
      @(negedge hclk);
      while (!smc_hready) begin
        low_cycles++;
        if (!smc_n_cs) begin                 // Pins inside the CS window
          check_value("smc_n_be", 32'(smc_n_be), 32'(exp_n_be));
          check_value("smc_n_wr", 32'(smc_n_wr), 32'(!tbl_write[i]));
          check_value("smc_n_ext_oe", 32'(smc_n_ext_oe), 32'(!tbl_write[i]));
        end
        @(negedge hclk);
      end
      check_value("hready_low_cycles", 32'(low_cycles), 32'(ACCESS_CYCLES));
      if (tbl_write[i]) begin
        for (int l = 0; l < 4; l++) begin
          if (mask[l])
            shadow[tbl_addr[i][5:2]][8*l +: 8] = tbl_data[i][8*l +: 8];
        end
      end else begin
        check_value("smc_hrdata", smc_hrdata, shadow[tbl_addr[i][5:2]]);
      end
    end

    repeat (2) @(posedge hclk);
    if (error_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Verification failed");
      $fatal(1, "errors seen");
    end
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge hclk);
    $display("Timeout: the test did not finish in %0d cycles", WATCHDOG_CYCLES);
    $display("Verification failed");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== smc_lite.f ====
logic/smc_bus_pkg.sv
logic/smc_timing_pkg.sv
logic/smc_ahb_slave.sv
logic/smc_sequencer.sv
logic/smc_strobe.sv
logic/smc_addr.sv
logic/smc_lite.sv
dv/smc_lite_sva.sv
dv/smc_lite_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the smc_lite testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f smc_lite.f --top-module smc_lite_tb \
  --Mdir obj_dir -o smc_lite_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/smc_lite_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
exit 0
